// ==== Makefile ====
# Verilator build and run for the boot loader testbench

TOP := tb_boot_loader
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir

# the log decides, the simulator exit status does not
run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
+incdir+verilog
verilog/loader_pkg.sv
verilog/uart_rx.sv
verilog/word_loader.sv
verilog/imem_sram.sv
verilog/boot_loader_top.sv
testbench/tb_checker.sv
testbench/tb_boot_loader.sv

// ==== testbench/tb_boot_loader.sv ====
`timescale 1ns/1ps
`include "loader_defs.svh"

module tb_boot_loader import loader_pkg::*; ();

    localparam logic [31:0] SEED = 32'hefd0_2f51;
    localparam int RESET_CYCLES  = 16;
    localparam int LOAD_WORDS    = 12;   // random image words
    // 61 frames at 10 bits of 10 clocks is about 6100 cycles, plus fetches and gaps
    localparam int TIMEOUT_CYCLES = 10_000;

    logic        clk;
    logic        resetn;
    logic        uart_rxd;
    logic        uart_rx_en;
    logic        fetch_en;
    imem_addr_t  fetch_addr;
    logic        uart_rx_valid;
    logic        uart_rx_break;
    uart_byte_t  uart_rx_data;
    imem_word_t  fetch_data;
    word_count_t word_count;
    logic        write_done;

    uart_byte_t  sent_bytes [0:63];   // every byte sent with the receiver enabled
    int          sent_count = 0;
    int          cycle_count = 0;
    logic        run_done;
    logic        checks_done;
    int          bytes_seen;
    int          value_errors;
    int          other_errors;

    // ------------------------------------------------------------------------
    // clock, timeout, DUT and checker
    // ------------------------------------------------------------------------

    initial clk = 1'b0;
    always #50 clk = ~clk;   // 100 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the load or fetch sequence never finished",
                     cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    boot_loader_top u_boot_loader_top (
        .clk           (clk),
        .resetn        (resetn),
        .uart_rxd      (uart_rxd),
        .uart_rx_en    (uart_rx_en),
        .uart_rx_valid (uart_rx_valid),
        .uart_rx_break (uart_rx_break),
        .uart_rx_data  (uart_rx_data),
        .fetch_en      (fetch_en),
        .fetch_addr    (fetch_addr),
        .fetch_data    (fetch_data),
        .word_count    (word_count),
        .write_done    (write_done)
    );

    tb_checker u_checker (
        .clk           (clk),
        .resetn        (resetn),
        .uart_rx_en    (uart_rx_en),
        .uart_rx_valid (uart_rx_valid),
        .uart_rx_break (uart_rx_break),
        .uart_rx_data  (uart_rx_data),
        .fetch_en      (fetch_en),
        .fetch_addr    (fetch_addr),
        .fetch_data    (fetch_data),
        .word_count    (word_count),
        .write_done    (write_done),
        .run_done      (run_done),
        .checks_done   (checks_done),
        .bytes_seen    (bytes_seen),
        .value_errors  (value_errors),
        .other_errors  (other_errors)
    );

    // ------------------------------------------------------------------------
    // stimulus tasks, all entered right after a rising edge
    // ------------------------------------------------------------------------

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic send_bit(input logic value);
        uart_rxd <= value;
        idle_cycles(`CYCLES_PER_BIT);
    endtask

    // start bit, data lsb first, one stop bit
    task automatic send_byte(input uart_byte_t value);
        int i;
        send_bit(1'b0);
        for (i = 0; i < `PAYLOAD_BITS; i++) begin
            send_bit(value[i]);
        end
        send_bit(1'b1);
    endtask

    task automatic send_logged(input uart_byte_t value);
        sent_bytes[sent_count] = value;   // listed before the frame starts
        sent_count = sent_count + 1;
        send_byte(value);
    endtask

    task automatic send_word(input imem_word_t value);
        int lane;
        for (lane = 0; lane < `BYTES_PER_WORD; lane++) begin
            send_logged(value[lane*`PAYLOAD_BITS +: `PAYLOAD_BITS]);
        end
    endtask

    // one cycle request, then a gap so responses never overlap
    task automatic fetch_word(input int addr);
        fetch_en   <= 1'b1;
        fetch_addr <= imem_addr_t'(addr);
        @(posedge clk);
        fetch_en   <= 1'b0;
        idle_cycles(2);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [31:0] rnd;
        int          w;
        resetn     = 1'b0;
        uart_rxd   = 1'b1;   // line idle
        uart_rx_en = 1'b0;
        fetch_en   = 1'b0;
        fetch_addr = '0;
        run_done   = 1'b0;
        void'($urandom(SEED));
        idle_cycles(RESET_CYCLES);
        resetn <= 1'b1;
        idle_cycles(4);

        // receiver disabled, this frame must vanish
        rnd = $urandom;
        send_byte(rnd[7:0]);
        idle_cycles(2 * `CYCLES_PER_BIT);
        uart_rx_en <= 1'b1;
        idle_cycles(2 * `CYCLES_PER_BIT);

        for (w = 0; w < LOAD_WORDS; w++) begin
            rnd = $urandom;
            if (rnd == `LOAD_END_WORD) begin
                rnd = '0;   // keep the terminator out of the image
            end
            send_word(rnd);
        end
        send_word(32'h0000_0000);   // zero word, both pairs of zero bytes
        send_word(`LOAD_END_WORD);
        while (!write_done) begin
            @(posedge clk);
        end

        // trailing bytes after the image is closed
        rnd = $urandom;
        send_word(rnd);
        while (bytes_seen < sent_count) begin
            @(posedge clk);
        end

        for (w = 0; w <= LOAD_WORDS; w++) begin
            fetch_word(w);
        end
        fetch_word(0);   // refetch after the late bytes

        run_done <= 1'b1;
        while (!checks_done) begin
            @(posedge clk);
        end
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_checker.sv ====
`timescale 1ns/1ps
`include "loader_defs.svh"

// watches the DUT ports, samples on the falling edge where everything is settled
module tb_checker import loader_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        uart_rx_en,
    input  logic        uart_rx_valid,
    input  logic        uart_rx_break,
    input  uart_byte_t  uart_rx_data,
    input  logic        fetch_en,
    input  imem_addr_t  fetch_addr,
    input  imem_word_t  fetch_data,
    input  word_count_t word_count,
    input  logic        write_done,
    input  logic        run_done,
    output logic        checks_done,
    output int          bytes_seen,
    output int          value_errors,
    output int          other_errors
);

    localparam int FINAL_WORDS   = 13;   // 12 random plus the zero word
    localparam int FINAL_FETCHES = 14;   // addresses 0 to 12 and one refetch

    word_count_t exp_count;      // words the loader should have stored
    logic        exp_done;
    logic        fetch_pending;  // request seen, response due next edge
    imem_addr_t  pending_addr;
    int          fetches_checked;
    uart_byte_t  exp_byte;

    initial begin
        checks_done     = 1'b0;
        bytes_seen      = 0;
        value_errors    = 0;
        other_errors    = 0;
        exp_count       = '0;
        exp_done        = 1'b0;
        fetch_pending   = 1'b0;
        pending_addr    = '0;
        fetches_checked = 0;
    end

    // expected word at an address, bytes 4a..4a+3 little endian
    function automatic imem_word_t ref_word(input int addr);
        imem_word_t w;
        int         i;
        w = '0;
        for (i = 0; i < `BYTES_PER_WORD; i++) begin
            w[i*`PAYLOAD_BITS +: `PAYLOAD_BITS] =
                tb_boot_loader.sent_bytes[addr*`BYTES_PER_WORD + i];
        end
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("FAIL time %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
        value_errors = value_errors + 1;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR time %0t: %s", $time, msg);
        other_errors = other_errors + 1;
    endtask

    // ------------------------------------------------------------------------
    // comparison process
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        if (!resetn) begin
            if (uart_rx_valid !== 1'b0) report_mismatch("uart_rx_valid", 0, 32'(uart_rx_valid));
            if (uart_rx_break !== 1'b0) report_mismatch("uart_rx_break", 0, 32'(uart_rx_break));
            if (uart_rx_data !== '0) report_mismatch("uart_rx_data", 0, 32'(uart_rx_data));
            if (write_done !== 1'b0) report_mismatch("write_done", 0, 32'(write_done));
            if (word_count !== '0) report_mismatch("word_count", 0, 32'(word_count));
        end else begin
            // status lags the fourth byte by one cycle, so compare before updating
            if (word_count !== exp_count)
                report_mismatch("word_count", 32'(exp_count), 32'(word_count));
            if (write_done !== exp_done)
                report_mismatch("write_done", 32'(exp_done), 32'(write_done));
            if (uart_rx_break && !uart_rx_valid)
                report_problem("uart_rx_break high without uart_rx_valid");

            if (fetch_pending) begin
                if (fetch_data !== ref_word(int'(pending_addr)))
                    report_mismatch("fetch_data", ref_word(int'(pending_addr)), fetch_data);
                fetches_checked = fetches_checked + 1;
            end
            fetch_pending = fetch_en;
            pending_addr  = fetch_addr;

            if (uart_rx_valid) begin
                if (!uart_rx_en)
                    report_problem("uart_rx_valid appeared while the receiver was disabled");
                if (bytes_seen >= tb_boot_loader.sent_count) begin
                    report_problem("uart_rx_valid for a byte that was never sent");
                end else begin
                    exp_byte = tb_boot_loader.sent_bytes[bytes_seen];
                    if (uart_rx_data !== exp_byte)
                        report_mismatch("uart_rx_data", 32'(exp_byte), 32'(uart_rx_data));
                    if (uart_rx_break !== (exp_byte == '0))
                        report_mismatch("uart_rx_break", 32'(exp_byte == '0),
                                        32'(uart_rx_break));
                    // last byte of a word closes it
                    if (!exp_done && (bytes_seen % `BYTES_PER_WORD) == `BYTES_PER_WORD - 1) begin
                        if (ref_word(bytes_seen / `BYTES_PER_WORD) == `LOAD_END_WORD)
                            exp_done = 1'b1;   // terminator, not counted
                        else
                            exp_count = exp_count + 1'b1;
                    end
                end
                bytes_seen = bytes_seen + 1;
            end

            if (run_done && !checks_done) begin
                if (bytes_seen != tb_boot_loader.sent_count)
                    report_problem("not every sent byte came back on uart_rx_valid");
                if (word_count !== word_count_t'(FINAL_WORDS))
                    report_mismatch("word_count", FINAL_WORDS, 32'(word_count));
                if (write_done !== 1'b1)
                    report_problem("write_done did not stay high after the terminator");
                if (fetches_checked != FINAL_FETCHES)
                    report_problem("fewer fetch responses were checked than requested");
                checks_done = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/boot_loader_top.sv ====
`timescale 1ns/1ps
`include "loader_defs.svh"

// uart boot loader: serial bytes in, 32 bit words into the instruction
// memory, separate fetch port out
module boot_loader_top import loader_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // serial side
    input  logic        uart_rxd,
    input  logic        uart_rx_en,
    output logic        uart_rx_valid,
    output logic        uart_rx_break,
    output uart_byte_t  uart_rx_data,
    // fetch side
    input  logic        fetch_en,
    input  imem_addr_t  fetch_addr,
    output imem_word_t  fetch_data,
    // load status
    output word_count_t word_count,
    output logic        write_done
);

    // loader to memory
    logic       wr_en;
    imem_addr_t wr_addr;
    imem_word_t wr_data;

    // ------------------------------------------------------------------------
    // serial receiver
    // ------------------------------------------------------------------------

    uart_rx u_uart_rx (
        .clk        (clk),
        .resetn     (resetn),
        .uart_rxd   (uart_rxd),
        .uart_rx_en (uart_rx_en),
        .rx_valid   (uart_rx_valid),
        .rx_break   (uart_rx_break),
        .rx_data    (uart_rx_data)
    );

    // ------------------------------------------------------------------------
    // loader and memory
    // ------------------------------------------------------------------------

    word_loader u_word_loader (
        .clk        (clk),
        .resetn     (resetn),
        .rx_valid   (uart_rx_valid),
        .rx_data    (uart_rx_data),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .word_count (word_count),
        .write_done (write_done)
    );

    imem_sram u_imem_sram (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .fetch_en   (fetch_en),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data)
    );

endmodule

// ==== verilog/imem_sram.sv ====
`timescale 1ns/1ps
`include "loader_defs.svh"

// instruction memory model, one write port from the loader and one
// read port for instruction fetch
module imem_sram import loader_pkg::*; (
    input  logic       clk,
    // write port
    input  logic       wr_en,
    input  imem_addr_t wr_addr,
    input  imem_word_t wr_data,
    // fetch port
    input  logic       fetch_en,
    input  imem_addr_t fetch_addr,
    output imem_word_t fetch_data   // valid the cycle after fetch_en
);

    imem_word_t mem [`IMEM_DEPTH];  // contents undefined until loaded

    // ------------------------------------------------------------------------
    // write port
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;  // lands at this edge
        end
    end

    // ------------------------------------------------------------------------
    // fetch port
    // ------------------------------------------------------------------------

    // registered read, holds between requests
    // a same-address write in the same cycle is not forwarded,
    // the fetch sees the previous word
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            fetch_data <= mem[fetch_addr];
        end
    end

endmodule

// ==== verilog/loader_defs.svh ====
`ifndef LOADER_DEFS_SVH
`define LOADER_DEFS_SVH

// ------------------------------------------------------------------------
// clocking and serial line
// ------------------------------------------------------------------------

`define CLK_HZ          10_000_000              // system clock
`define BIT_RATE        1_000_000               // uart bits per second
`define CYCLES_PER_BIT  (`CLK_HZ / `BIT_RATE)   // 10 clocks per bit
`define PAYLOAD_BITS    8                       // data bits per frame, lsb first

// ------------------------------------------------------------------------
// instruction memory geometry
// ------------------------------------------------------------------------

`define BYTES_PER_WORD  4                       // bytes packed per word
`define IMEM_ADDR_W     8
`define IMEM_DATA_W     32
`define IMEM_DEPTH      256                     // words

// end of image marker, never stored
`define LOAD_END_WORD   32'hffff_ffff

`endif

// ==== verilog/loader_pkg.sv ====
`include "loader_defs.svh"

package loader_pkg;

    // receiver fsm
    typedef enum logic [1:0] {
        idle,   // line high, waiting for a start edge
        start,  // inside the start bit
        recv,   // shifting in data bits
        stop    // first half of the stop bit
    } uart_state_t;

    // one received character
    typedef logic [`PAYLOAD_BITS-1:0] uart_byte_t;

    // memory side
    typedef logic [`IMEM_ADDR_W-1:0] imem_addr_t;
    typedef logic [`IMEM_DATA_W-1:0] imem_word_t;

    // one extra bit so a full memory (256) is representable
    typedef logic [`IMEM_ADDR_W:0] word_count_t;

    // next byte position inside the word being packed
    typedef logic [$clog2(`BYTES_PER_WORD)-1:0] byte_lane_t;

endpackage

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps
`include "loader_defs.svh"

module uart_rx import loader_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       uart_rxd,     // serial pin, idles high
    input  logic       uart_rx_en,   // freezes the synchronizer when low
    output logic       rx_valid,     // one cycle per received byte
    output logic       rx_break,     // byte was all zeros
    output uart_byte_t rx_data
);

    localparam int CNT_W = $clog2(`CYCLES_PER_BIT);
    localparam int BIT_W = $clog2(`PAYLOAD_BITS);

    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`CYCLES_PER_BIT - 1);
    localparam logic [CNT_W-1:0] BIT_MID  = CNT_W'(`CYCLES_PER_BIT / 2 - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`PAYLOAD_BITS - 1);

    logic             rxd_meta;    // first sync stage
    logic             rxd_sync;    // safe to use from here on
    uart_state_t      state;
    logic [CNT_W-1:0] cycle_cnt;   // clocks within the current bit
    logic [BIT_W-1:0] bit_cnt;     // data bit index
    uart_byte_t       shift_reg;
    logic             mid_bit;
    logic             bit_end;

    // ------------------------------------------------------------------------
    // input synchronizer
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rxd_meta <= 1'b1;  // line idle level
            rxd_sync <= 1'b1;
        end else if (uart_rx_en) begin
            rxd_meta <= uart_rxd;
            rxd_sync <= rxd_meta;
        end
    end

    // ------------------------------------------------------------------------
    // bit timing
    // ------------------------------------------------------------------------

    assign mid_bit = (cycle_cnt == BIT_MID);   // sample point
    assign bit_end = (cycle_cnt == BIT_LAST);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cycle_cnt <= '0;
        end else if (state == idle || bit_end) begin
            cycle_cnt <= '0;  // restart on every bit boundary
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == recv && mid_bit) begin
            shift_reg <= {rxd_sync, shift_reg[`PAYLOAD_BITS-1:1]};
        end
    end

    // ------------------------------------------------------------------------
    // frame fsm
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= idle;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
            rx_break <= 1'b0;
            rx_data  <= '0;
        end else begin
            rx_valid <= 1'b0;  // strobes, high for one cycle only
            rx_break <= 1'b0;
            case (state)
                idle: begin
                    bit_cnt <= '0;
                    if (!rxd_sync) begin
                        state <= start;  // falling edge seen
                    end
                end
                start: begin
                    if (mid_bit && rxd_sync) begin
                        state <= idle;  // glitch, not a real start bit
                    end else if (bit_end) begin
                        state <= recv;
                    end
                end
                recv: begin
                    if (bit_end) begin
                        if (bit_cnt == LAST_BIT) begin
                            state <= stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                stop: begin
                    // hand the byte over in the middle of the stop bit
                    if (mid_bit) begin
                        rx_valid <= 1'b1;
                        rx_break <= (shift_reg == '0);
                        rx_data  <= shift_reg;
                        state    <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    // break is only meaningful alongside a byte
    a_break_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
        rx_break |-> rx_valid);

    // downstream counts bytes by strobe, so never two in a row
    a_valid_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        rx_valid |=> !rx_valid);

endmodule

// ==== verilog/word_loader.sv ====
`timescale 1ns/1ps
`include "loader_defs.svh"

module word_loader import loader_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        rx_valid,
    input  uart_byte_t  rx_data,
    output logic        wr_en,       // one cycle write strobe to the sram
    output imem_addr_t  wr_addr,
    output imem_word_t  wr_data,
    output word_count_t word_count,  // words stored so far
    output logic        write_done   // sticky until reset
);

    localparam byte_lane_t LANE_LAST = byte_lane_t'(`BYTES_PER_WORD - 1);

    byte_lane_t lane;        // where the next byte goes
    imem_word_t word_buf;    // partially packed word
    imem_word_t word_next;   // word_buf with the incoming byte merged in
    logic       mem_full;
    logic       accept;
    logic       word_full;

    // ------------------------------------------------------------------------
    // byte packing
    // ------------------------------------------------------------------------

    assign mem_full  = (word_count == word_count_t'(`IMEM_DEPTH));
    assign accept    = rx_valid && !write_done && !mem_full;
    assign word_full = accept && (lane == LANE_LAST);  // fourth byte

    // little endian, lane 0 is bits 7:0
    always_comb begin
        word_next = word_buf;
        word_next[lane*`PAYLOAD_BITS +: `PAYLOAD_BITS] = rx_data;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word_buf <= word_next;
        end
        if (word_full) begin
            wr_data <= word_next;
            wr_addr <= word_count[`IMEM_ADDR_W-1:0];  // first word at 0
        end
    end

    // ------------------------------------------------------------------------
    // write control
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lane       <= '0;
            wr_en      <= 1'b0;
            word_count <= '0;
            write_done <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (mem_full) begin
                write_done <= 1'b1;  // memory exhausted, stop loading
            end
            if (accept) begin
                lane <= lane + 1'b1;  // wraps back to lane 0
            end
            if (word_full) begin
                if (word_next == `LOAD_END_WORD) begin
                    // terminator is neither stored nor counted
                    write_done <= 1'b1;
                end else begin
                    wr_en      <= 1'b1;
                    word_count <= word_count + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    // the image is closed once done, no late writes into it
    a_no_write_when_done: assert property (@(posedge clk) disable iff (!resetn)
        write_done |-> !wr_en);

endmodule
